/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath widths
`define CPU_DATA_W   8
`define CPU_INSTR_W  16
`define CPU_IMM_W    6

// Register file
`define CPU_REG_AW   3
`define CPU_REG_NUM  (1 << `CPU_REG_AW)

// Data memory, one byte per address
`define CPU_MEM_AW    8
`define CPU_MEM_DEPTH (1 << `CPU_MEM_AW)

`endif

/* cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] data_t;
  typedef logic [`CPU_REG_AW-1:0] reg_addr_t;
  typedef logic [`CPU_MEM_AW-1:0] mem_addr_t;

  // Immediate is {rd, funct}
  typedef struct packed {
    logic [3:0] opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [2:0] funct;
  } instr_t;

  typedef enum logic [3:0] {
    OP_RTYPE = 4'd0,
    OP_SHIFT = 4'd1,
    OP_ADDI  = 4'd2,
    OP_LW    = 4'd3,
    OP_SW    = 4'd4,
    OP_LUI   = 4'd5
  } opcode_e;

  // Codes 0 to 7 follow the R-type funct field
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_NOR = 4'd5,
    ALU_SLT = 4'd6,
    ALU_MUL = 4'd7,
    ALU_SLL = 4'd8,
    ALU_SRL = 4'd9,
    ALU_SRA = 4'd10
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_HI  = 2'd2,
    WB_LO  = 2'd3
  } wb_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;    // B is the sign-extended immediate
    logic    lui;
    logic    reg_write;
    logic    dst_rd;     // Else rt
    logic    mem_write;
    logic    hilo_write;
    wb_sel_e wb_sel;
  } ctrl_t;

  typedef enum logic {
    IDLE = 1'b0,
    DONE = 1'b1
  } step_state_e;

endpackage

/* instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
  input  logic             C,
  input  logic             rst,
  input  logic             step_req,
  input  cpu_pkg::instr_t  instr,
  output logic             step_ack,
  output logic             commit,
  output cpu_pkg::ctrl_t   ctrl
);

  cpu_pkg::step_state_e state;

  assign commit   = (state == cpu_pkg::IDLE) && step_req;
  assign step_ack = (state == cpu_pkg::DONE);

  always_ff @(posedge C) begin
    if (rst) begin
      state <= cpu_pkg::IDLE;
    end else if (commit) begin
      state <= cpu_pkg::DONE;
    end else if (state == cpu_pkg::DONE && !step_req) begin
      state <= cpu_pkg::IDLE; // Request released
    end
  end

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = cpu_pkg::ALU_ADD;
    ctrl.wb_sel = cpu_pkg::WB_ALU;
    case (instr.opcode)
      cpu_pkg::OP_RTYPE: begin
        ctrl.alu_op = cpu_pkg::alu_op_e'({1'b0, instr.funct});
        if (instr.funct == 3'd7) begin
          ctrl.hilo_write = 1'b1; // mul only touches HI/LO
        end else begin
          ctrl.reg_write = 1'b1;
          ctrl.dst_rd    = 1'b1;
        end
      end
      cpu_pkg::OP_SHIFT: begin
        ctrl.dst_rd = 1'b1;
        case (instr.funct)
          3'd0: ctrl.alu_op = cpu_pkg::ALU_SLL;
          3'd1: ctrl.alu_op = cpu_pkg::ALU_SRL;
          3'd2: ctrl.alu_op = cpu_pkg::ALU_SRA;
          3'd4: ctrl.wb_sel = cpu_pkg::WB_HI;
          3'd5: ctrl.wb_sel = cpu_pkg::WB_LO;
          default: ctrl.dst_rd = 1'b0;
        endcase
        ctrl.reg_write = ctrl.dst_rd;
      end
      cpu_pkg::OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      cpu_pkg::OP_LW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = cpu_pkg::WB_MEM;
      end
      cpu_pkg::OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      cpu_pkg::OP_LUI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.lui       = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ; // No-op
    endcase
  end

  // Instruction held across the commit edge
  assert property (@(posedge C) disable iff (rst)
    step_req && $past(step_req) && !$past(step_ack) |-> $stable(instr));

  // Request held until acknowledged
  assert property (@(posedge C) disable iff (rst)
    step_req && !step_ack |=> step_req);

endmodule

/* alu_unit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu_unit (
  input  logic             C,
  input  logic             rst,
  input  logic             commit,
  input  cpu_pkg::ctrl_t   ctrl,
  input  cpu_pkg::instr_t  instr,
  input  cpu_pkg::data_t   rs_data,
  input  cpu_pkg::data_t   rt_data,
  output cpu_pkg::data_t   alu_result,
  output cpu_pkg::data_t   hi,
  output cpu_pkg::data_t   lo
);

  logic [`CPU_IMM_W-1:0]    imm;
  cpu_pkg::data_t           imm_sext;
  cpu_pkg::data_t           lui_val;
  cpu_pkg::data_t           a_op;
  cpu_pkg::data_t           b_op;
  logic [2:0]               shamt;
  logic [2*`CPU_DATA_W-1:0] product;

  assign imm      = {instr.rd, instr.funct};
  assign imm_sext = {{(`CPU_DATA_W - `CPU_IMM_W){imm[`CPU_IMM_W-1]}}, imm};
  assign lui_val  = {imm[3:0], 4'b0000};
  assign shamt    = instr.rs; // Shift amount from the rs field

  // LUI adds its value to zero
  assign a_op = ctrl.lui ? '0 : rs_data;

  always_comb begin
    if (ctrl.lui) begin
      b_op = lui_val;
    end else if (ctrl.alu_src) begin
      b_op = imm_sext;
    end else begin
      b_op = rt_data;
    end
  end

  assign product = a_op * b_op;

  always_comb begin
    case (ctrl.alu_op)
      cpu_pkg::ALU_ADD: alu_result = a_op + b_op;
      cpu_pkg::ALU_SUB: alu_result = a_op - b_op;
      cpu_pkg::ALU_AND: alu_result = a_op & b_op;
      cpu_pkg::ALU_OR:  alu_result = a_op | b_op;
      cpu_pkg::ALU_XOR: alu_result = a_op ^ b_op;
      cpu_pkg::ALU_NOR: alu_result = ~(a_op | b_op);
      cpu_pkg::ALU_SLT: alu_result = (a_op < b_op) ? 8'd1 : 8'd0; // Unsigned
      cpu_pkg::ALU_MUL: alu_result = product[`CPU_DATA_W-1:0];
      cpu_pkg::ALU_SLL: alu_result = b_op << shamt;
      cpu_pkg::ALU_SRL: alu_result = b_op >> shamt;
      cpu_pkg::ALU_SRA: alu_result = $signed(b_op) >>> shamt;
      default:          alu_result = '0;
    endcase
  end

  always_ff @(posedge C) begin
    if (rst) begin
      hi <= '0;
      lo <= '0;
    end else if (commit && ctrl.hilo_write) begin
      hi <= product[2*`CPU_DATA_W-1:`CPU_DATA_W];
      lo <= product[`CPU_DATA_W-1:0];
    end
  end

  assert property (@(posedge C) disable iff (rst)
    ctrl.hilo_write |-> ctrl.alu_op == cpu_pkg::ALU_MUL);

endmodule

/* data_mem.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module data_mem (
  input  logic               C,
  input  logic               commit,
  input  cpu_pkg::ctrl_t     ctrl,
  input  cpu_pkg::mem_addr_t addr,
  input  cpu_pkg::data_t     store_data,
  output cpu_pkg::data_t     load_data
);

  cpu_pkg::data_t mem [0:`CPU_MEM_DEPTH-1];

  always_ff @(posedge C) begin
    if (commit && ctrl.mem_write) begin
      mem[addr] <= store_data;
    end
  end

  assign load_data = mem[addr]; // Asynchronous read

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file (
  input  logic               C,
  input  logic               rst,
  input  logic               commit,
  input  cpu_pkg::ctrl_t     ctrl,
  input  cpu_pkg::instr_t    instr,
  input  cpu_pkg::data_t     alu_result,
  input  cpu_pkg::data_t     load_data,
  input  cpu_pkg::data_t     hi,
  input  cpu_pkg::data_t     lo,
  input  cpu_pkg::reg_addr_t reg_sel,
  output cpu_pkg::data_t     rs_data,
  output cpu_pkg::data_t     rt_data,
  output cpu_pkg::data_t     reg_view
);

  cpu_pkg::data_t     regs [0:`CPU_REG_NUM-1];
  cpu_pkg::reg_addr_t wr_addr;
  cpu_pkg::data_t     wr_data;

  assign wr_addr = ctrl.dst_rd ? instr.rd : instr.rt;

  always_comb begin
    case (ctrl.wb_sel)
      cpu_pkg::WB_MEM: wr_data = load_data;
      cpu_pkg::WB_HI:  wr_data = hi;
      cpu_pkg::WB_LO:  wr_data = lo;
      default:         wr_data = alu_result;
    endcase
  end

  always_ff @(posedge C) begin
    if (rst) begin
      for (int i = 0; i < `CPU_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (commit && ctrl.reg_write) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs_data  = regs[instr.rs];
  assign rt_data  = regs[instr.rt];
  assign reg_view = regs[reg_sel]; // Debug view

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic               C,
  input  logic               rst,
  input  logic               step_req,
  input  cpu_pkg::instr_t    instr,
  output logic               step_ack,
  input  cpu_pkg::reg_addr_t reg_sel,
  output cpu_pkg::data_t     reg_view,
  output cpu_pkg::data_t     hi,
  output cpu_pkg::data_t     lo
);

  logic               commit;
  cpu_pkg::ctrl_t     ctrl;
  cpu_pkg::data_t     rs_data;
  cpu_pkg::data_t     rt_data;
  cpu_pkg::data_t     alu_result;
  cpu_pkg::data_t     load_data;
  cpu_pkg::mem_addr_t mem_addr;

  // Loads and stores use the ALU sum rs + imm
  assign mem_addr = alu_result;

  instr_decode i_instr_decode (
    .C        (C),
    .rst      (rst),
    .step_req (step_req),
    .instr    (instr),
    .step_ack (step_ack),
    .commit   (commit),
    .ctrl     (ctrl)
  );

  alu_unit i_alu_unit (
    .C          (C),
    .rst        (rst),
    .commit     (commit),
    .ctrl       (ctrl),
    .instr      (instr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .alu_result (alu_result),
    .hi         (hi),
    .lo         (lo)
  );

  data_mem i_data_mem (
    .C          (C),
    .commit     (commit),
    .ctrl       (ctrl),
    .addr       (mem_addr),
    .store_data (rt_data),
    .load_data  (load_data)
  );

  reg_file i_reg_file (
    .C          (C),
    .rst        (rst),
    .commit     (commit),
    .ctrl       (ctrl),
    .instr      (instr),
    .alu_result (alu_result),
    .load_data  (load_data),
    .hi         (hi),
    .lo         (lo),
    .reg_sel    (reg_sel),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .reg_view   (reg_view)
  );

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu;

  localparam int NUM_STEPS   = 448; // Upper bound, LUI helpers included
  localparam int CYCLE_LIMIT = NUM_STEPS * 12 + 100;

  logic               C;
  logic               rst;
  logic               step_req;
  cpu_pkg::instr_t    instr;
  logic               step_ack;
  cpu_pkg::reg_addr_t reg_sel;
  cpu_pkg::data_t     reg_view;
  cpu_pkg::data_t     hi;
  cpu_pkg::data_t     lo;

  logic [31:0]        lfsr;
  int                 checks;
  int                 errors;
  int                 test_start;

  // Reference model state
  cpu_pkg::data_t     m_regs [0:`CPU_REG_NUM-1];
  cpu_pkg::data_t     m_hi;
  cpu_pkg::data_t     m_lo;
  cpu_pkg::data_t     m_mem [0:`CPU_MEM_DEPTH-1];
  cpu_pkg::mem_addr_t stored_q [$];

  cpu_top i_cpu_top (
    .C        (C),
    .rst      (rst),
    .step_req (step_req),
    .instr    (instr),
    .step_ack (step_ack),
    .reg_sel  (reg_sel),
    .reg_view (reg_view),
    .hi       (hi),
    .lo       (lo)
  );

  initial begin
    C = 1'b0;
    forever #20 C = ~C;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge C);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("TEST FAIL");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          k;
    val = '0;
    for (k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic cpu_pkg::reg_addr_t rand_reg();
    return cpu_pkg::reg_addr_t'(take_bits(3));
  endfunction

  function automatic cpu_pkg::instr_t make_instr(input logic [3:0] op,
      input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt,
      input cpu_pkg::reg_addr_t rd, input logic [2:0] funct);
    return cpu_pkg::instr_t'({op, rs, rt, rd, funct});
  endfunction

  function automatic cpu_pkg::instr_t make_imm(input logic [3:0] op,
      input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt, input logic [5:0] imm);
    return make_instr(op, rs, rt, imm[5:3], imm[2:0]);
  endfunction

  // Fits a 6-bit signed immediate
  function automatic bit in_imm_range(input cpu_pkg::data_t d);
    return d[7:5] == 3'b000 || d[7:5] == 3'b111;
  endfunction

  function automatic void apply_model(input cpu_pkg::instr_t ins);
    cpu_pkg::data_t     a;
    cpu_pkg::data_t     b;
    cpu_pkg::data_t     imm;
    cpu_pkg::data_t     res;
    cpu_pkg::mem_addr_t addr;
    logic [15:0]        prod;
    a    = m_regs[ins.rs];
    b    = m_regs[ins.rt];
    imm  = {{2{ins.rd[2]}}, ins.rd, ins.funct};
    addr = a + imm;
    case (ins.opcode)
      4'd0: begin
        case (ins.funct)
          3'd0: res = a + b;
          3'd1: res = a - b;
          3'd2: res = a & b;
          3'd3: res = a | b;
          3'd4: res = a ^ b;
          3'd5: res = ~(a | b);
          3'd6: res = (a < b) ? 8'h01 : 8'h00;
          default: res = '0;
        endcase
        if (ins.funct == 3'd7) begin
          prod = 16'(a) * 16'(b);
          m_hi = prod[15:8];
          m_lo = prod[7:0];
        end else begin
          m_regs[ins.rd] = res;
        end
      end
      4'd1: begin
        case (ins.funct)
          3'd0: m_regs[ins.rd] = b << ins.rs;
          3'd1: m_regs[ins.rd] = b >> ins.rs;
          3'd2: m_regs[ins.rd] = (b >> ins.rs) | (b[7] ? ~(8'hff >> ins.rs) : 8'h00);
          3'd4: m_regs[ins.rd] = m_hi;
          3'd5: m_regs[ins.rd] = m_lo;
          default: ;
        endcase
      end
      4'd2: m_regs[ins.rt] = a + imm;
      4'd3: m_regs[ins.rt] = m_mem[addr];
      4'd4: begin
        m_mem[addr] = b;
        stored_q.push_back(addr);
      end
      4'd5: m_regs[ins.rt] = {imm[3:0], 4'h0};
      default: ; // Opcodes 6 to 15
    endcase
  endfunction

  task automatic check_data(input string name, input cpu_pkg::data_t got,
                            input cpu_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_ack(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] step_ack: got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // One handshake, then all registers, hi and lo against the model
  task automatic run_step(input cpu_pkg::instr_t ins, input int hold_req);
    int gap;
    int drop_at;
    int lat;
    int i;
    gap     = int'(take_bits(2));
    drop_at = (hold_req < 0) ? int'(take_bits(2)) + 1 : hold_req + 1;
    repeat (gap) @(posedge C);
    @(posedge C);
    instr    <= ins;
    step_req <= 1'b1;
    reg_sel  <= '0;
    apply_model(ins);
    lat = 0;
    do begin
      @(negedge C);
      lat++;
    end while (step_ack !== 1'b1);
    if (lat != 2) begin
      errors++;
      $display("step_ack rose %0d edges after the request was seen instead of 1", lat - 1);
    end
    check_data("reg_view[0]", reg_view, m_regs[0]);
    // Sweep runs on while step_req is held and released
    for (i = 1; i < `CPU_REG_NUM; i++) begin
      @(posedge C);
      reg_sel <= cpu_pkg::reg_addr_t'(i);
      if (i == drop_at) begin
        step_req <= 1'b0;
      end
      @(negedge C);
      check_ack(step_ack, i <= drop_at);
      check_data($sformatf("reg_view[%0d]", i), reg_view, m_regs[i]);
    end
    while (step_ack) @(negedge C);
    check_data("hi", hi, m_hi);
    check_data("lo", lo, m_lo);
  endtask

  initial begin
    cpu_pkg::instr_t    ins;
    cpu_pkg::reg_addr_t r;
    cpu_pkg::mem_addr_t addr;
    cpu_pkg::data_t     diff;
    logic [5:0]         imm;
    int                 i;
    int                 j;
    int                 k;
    rst        = 1'b1;
    step_req   = 1'b0;
    instr      = '0;
    reg_sel    = '0;
    lfsr       = 32'h4099_fff8;
    checks     = 0;
    errors     = 0;
    test_start = 0;
    m_hi       = '0;
    m_lo       = '0;
    for (i = 0; i < `CPU_REG_NUM; i++) begin
      m_regs[i] = '0;
    end
    repeat (3) @(posedge C);
    rst <= 1'b0;

    for (i = 0; i < `CPU_REG_NUM; i++) begin
      @(posedge C);
      reg_sel <= cpu_pkg::reg_addr_t'(i);
      @(negedge C);
      check_data($sformatf("reg_view[%0d]", i), reg_view, 8'h00);
    end
    check_data("hi", hi, 8'h00);
    check_data("lo", lo, 8'h00);
    check_ack(step_ack, 1'b0);
    finish_test("1 reset values");

    for (i = 0; i < `CPU_REG_NUM; i++) begin
      r = cpu_pkg::reg_addr_t'(i);
      run_step(make_imm(cpu_pkg::OP_ADDI, r, r, 6'(take_bits(6))), -1);
    end
    for (i = 0; i < 200; i++) begin
      ins = make_instr(cpu_pkg::OP_RTYPE, rand_reg(), rand_reg(), rand_reg(),
                       3'(take_bits(3) % 7));
      run_step(ins, -1);
    end
    finish_test("2 r-type alu");

    for (i = 0; i < 60; i++) begin
      k = int'(take_bits(2));
      if (k == 0) begin
        imm = 6'(take_bits(5)) | 6'h20; // Negative
        ins = make_imm(cpu_pkg::OP_ADDI, rand_reg(), rand_reg(), imm);
      end else if (k == 1) begin
        ins = make_imm(cpu_pkg::OP_LUI, rand_reg(), rand_reg(), 6'(take_bits(6)));
      end else begin
        ins = make_instr(cpu_pkg::OP_SHIFT, rand_reg(), rand_reg(), rand_reg(),
                         3'(take_bits(2) % 3));
      end
      run_step(ins, -1);
    end
    finish_test("3 addi, lui and shifts");

    for (i = 0; i < 30; i++) begin
      run_step(make_instr(cpu_pkg::OP_RTYPE, rand_reg(), rand_reg(), rand_reg(), 3'd7), -1);
      run_step(make_instr(cpu_pkg::OP_SHIFT, rand_reg(), rand_reg(), rand_reg(), 3'd4), -1);
      run_step(make_instr(cpu_pkg::OP_SHIFT, rand_reg(), rand_reg(), rand_reg(), 3'd5), -1);
    end
    finish_test("4 mul, mfhi and mflo");

    for (i = 0; i < 20; i++) begin
      run_step(make_imm(cpu_pkg::OP_SW, rand_reg(), rand_reg(), 6'(take_bits(6))), -1);
    end
    for (i = 0; i < 20; i++) begin
      k    = int'(take_bits(5)) % stored_q.size();
      addr = stored_q[k];
      r    = rand_reg();
      diff = addr - m_regs[r];
      for (j = 0; j < 7 && !in_imm_range(diff); j++) begin
        r    = r + 3'd1;
        diff = addr - m_regs[r];
      end
      if (!in_imm_range(diff)) begin
        // No base register in reach, so LUI sets one up
        run_step(make_imm(cpu_pkg::OP_LUI, r, r, {2'b00, addr[7:4]}), -1);
        diff = {4'h0, addr[3:0]};
      end
      run_step(make_imm(cpu_pkg::OP_LW, r, rand_reg(), diff[5:0]), -1);
    end
    finish_test("5 store and load");

    for (i = 0; i < 10; i++) begin
      r = rand_reg();
      run_step(make_imm(cpu_pkg::OP_ADDI, r, r, 6'd1), 3); // Held request
    end
    for (i = 0; i < 20; i++) begin
      ins = make_instr(4'(6 + take_bits(4) % 10), rand_reg(), rand_reg(), rand_reg(),
                       3'(take_bits(3)));
      run_step(ins, -1);
    end
    finish_test("6 handshake and no-ops");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
cpu_pkg.sv
instr_decode.sv
alu_unit.sv
data_mem.sv
reg_file.sv
cpu_top.sv
tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and take the result from the log
rm -f sim.log &&
verilator --binary --timing --assert --top-module tb_cpu -f tb.f -o sim_cpu &&
./obj_dir/sim_cpu | tee sim.log ||
{ echo "build or run failed"; exit 1; }
grep -qx "TEST PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
